//--- common/uartFramePkg.sv
// UART frame definitions
// Byte and bit position types, transmitter states, line select codes
// and the printable character range sent by the beacon

package uartFramePkg;

   typedef logic [7:0] uartByte;   // One character on the wire
   typedef logic [2:0] bitIndex;   // Data bit position within a frame

   // Transmitter FSM
   typedef enum logic [1:0] {
      txIdle  = 2'd0,   // Line at mark, waiting for a request
      txStart = 2'd1,   // Start bit on the line
      txData  = 2'd2,   // Data bit on the line
      txStop  = 2'd3    // Stop bit on the line
   } txState;

   // Level the serial line takes at the next tick
   typedef enum logic [1:0] {
      lineMark  = 2'd0,   // High
      lineStart = 2'd1,   // Low
      lineData  = 2'd2    // Shifter LSB
   } lineSelect;

   localparam uartByte FIRST_CHAR = 8'd48;    // '0'
   localparam uartByte LAST_CHAR  = 8'd122;   // 'z'
   localparam int      DATA_BITS  = 8;        // 8N1 frame

endpackage

//--- common/uartRatePkg.sv
// UART rate definitions
// Board clock, line rate, character rate and the derived dividers

package uartRatePkg;

   localparam int unsigned CLOCK_HZ  = 32'd50_000_000;   // DE2 50 MHz oscillator
   localparam int unsigned BAUD_RATE = 32'd115_200;

   // Clock cycles per bit, 434 at 115200 baud
   localparam int unsigned BAUD_DIVIDER = CLOCK_HZ / BAUD_RATE;

   // Characters per second, well below what the line can carry
   localparam int unsigned CHAR_RATE = 32'd20;

   // Clock cycles between send strobes
   localparam int unsigned CHAR_PERIOD = CLOCK_HZ / CHAR_RATE;

endpackage

//--- common/txLinkIf.sv
// Transmit link between the UART controller and its shifter
// Per-tick strobes plus the line level select

interface txLinkIf import uartFramePkg::*; ();

   logic      advance;   // Line register updates at this edge
   logic      load;      // Capture a new byte
   logic      shiftEn;   // Move right, old LSB to the line
   lineSelect lineSel;   // What the line shows

   // Controller side drives everything
   modport ctrl (
      output advance,
      output load,
      output shiftEn,
      output lineSel
   );

   // Shifter side only listens
   modport shift (
      input advance,
      input load,
      input shiftEn,
      input lineSel
   );

endinterface

//--- src/baudTimer.sv
// Baud timer
// Free running divider, one-cycle tick per bit period

module baudTimer #(
   parameter int unsigned BAUD_DIVIDER = uartRatePkg::BAUD_DIVIDER   // Cycles per bit
) (
   input  logic CLOCK_50,
   input  logic reset,
   output logic baudTick
);

   logic [31:0] baudCount;   // Cycles into the current bit

   ////////////////////////////////////////////////////////////////////////////
   // Divider
   ////////////////////////////////////////////////////////////////////////////

   // Tick registered on the wrap, so the first one lands
   // BAUD_DIVIDER cycles after reset goes away
   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         baudCount <= '0;
         baudTick  <= 1'b0;
      end else if (baudCount == 32'(BAUD_DIVIDER - 1)) begin
         baudCount <= '0;
         baudTick  <= 1'b1;   // Bit boundary
      end else begin
         baudCount <= baudCount + 32'd1;
         baudTick  <= 1'b0;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Single cycle pulse, the FSM steps once per bit
   tickIsPulse: assert property (
      @(posedge CLOCK_50) disable iff (reset)
      baudTick |=> !baudTick
   );

endmodule

//--- src/charSource.sv
// Character source
// Strobes the next printable code, '0' up to 'z' and round again,
// once per character period

module charSource import uartFramePkg::*; #(
   parameter int unsigned CHAR_PERIOD = uartRatePkg::CHAR_PERIOD   // Cycles per strobe
) (
   input  logic    CLOCK_50,
   input  logic    reset,
   output logic    sendNew,    // One-cycle request
   output uartByte charByte    // Held from strobe to strobe
);

   logic [31:0] rateCount;   // Cycles since the last strobe
   uartByte     nextChar;    // Code for the coming strobe

   ////////////////////////////////////////////////////////////////////////////
   // Rate counter and sequencer
   ////////////////////////////////////////////////////////////////////////////

   // charByte only moves on the strobe itself, so the transmitter can
   // pick it up at any later tick of the period
   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         rateCount <= '0;
         sendNew   <= 1'b0;
         charByte  <= FIRST_CHAR;
         nextChar  <= FIRST_CHAR;   // First strobe carries '0'
      end else if (rateCount == 32'(CHAR_PERIOD - 1)) begin
         rateCount <= '0;
         sendNew   <= 1'b1;
         charByte  <= nextChar;
         if (nextChar >= LAST_CHAR) begin
            nextChar <= FIRST_CHAR;   // Wrap after 'z'
         end else begin
            nextChar <= nextChar + 8'd1;
         end
      end else begin
         rateCount <= rateCount + 32'd1;
         sendNew   <= 1'b0;   // Strobe lasts one cycle
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Never anything outside the printable window
   charInRange: assert property (
      @(posedge CLOCK_50) disable iff (reset)
      charByte inside {[FIRST_CHAR:LAST_CHAR]}
   );

endmodule

//--- uartTx/txControl.sv
// UART transmit controller
// Start, eight data bits LSB first, stop, paced by the baud tick
// Holds one pending request and reports idle and frame done

module txControl import uartFramePkg::*; (
   input  logic CLOCK_50,
   input  logic reset,
   input  logic baudTick,   // One per bit period
   input  logic sendNew,    // Request from the character source
   txLinkIf.ctrl link,
   output logic txIdle,     // High between frames
   output logic frameDone   // One cycle at end of frame
);

   txState  state;
   logic    pending;    // Request waiting for the next tick
   bitIndex bitCount;   // Data bit now on the line
   logic    lastBit;

   assign lastBit = (bitCount == bitIndex'(DATA_BITS - 1));
   assign txIdle  = (state == uartFramePkg::txIdle);

   ////////////////////////////////////////////////////////////////////////////
   // Link strobes, only inside a tick cycle
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      link.advance = 1'b0;
      link.load    = 1'b0;
      link.shiftEn = 1'b0;
      link.lineSel = lineMark;
      if (baudTick) begin
         case (state)
            uartFramePkg::txIdle: begin
               if (pending) begin
                  link.advance = 1'b1;
                  link.load    = 1'b1;        // Byte in, line low
                  link.lineSel = lineStart;
               end
            end
            txStart: begin
               link.advance = 1'b1;
               link.shiftEn = 1'b1;           // Bit 0 out
               link.lineSel = lineData;
            end
            txData: begin
               link.advance = 1'b1;
               if (!lastBit) begin
                  link.shiftEn = 1'b1;        // Next data bit
                  link.lineSel = lineData;
               end
            end
            default: begin
               link.advance = 1'b1;           // Line held at mark
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // FSM, request latch, bit counter
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         state     <= uartFramePkg::txIdle;
         pending   <= 1'b0;
         bitCount  <= '0;
         frameDone <= 1'b0;
      end else begin
         frameDone <= 1'b0;

         // Requests during a frame, or on top of a pending one, are lost
         if (link.load) begin
            pending <= 1'b0;
         end else if (sendNew && txIdle && !pending) begin
            pending <= 1'b1;
         end

         if (baudTick) begin
            case (state)
               uartFramePkg::txIdle: begin
                  if (pending) begin
                     state <= txStart;
                  end
               end
               txStart: begin
                  state    <= txData;
                  bitCount <= '0;
               end
               txData: begin
                  if (lastBit) begin
                     state <= txStop;                  // Stop bit goes out
                  end else begin
                     bitCount <= bitCount + 3'd1;
                  end
               end
               default: begin
                  state     <= uartFramePkg::txIdle;   // Stop bit complete
                  frameDone <= 1'b1;
               end
            endcase
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   loadNotShift: assert property (
      @(posedge CLOCK_50) disable iff (reset)
      !(link.load && link.shiftEn)
   );

   // Done pulse only follows a tick edge
   doneOnTick: assert property (
      @(posedge CLOCK_50) disable iff (reset)
      frameDone |-> $past(baudTick)
   );

endmodule

//--- uartTx/txShifter.sv
// UART transmit shifter
// Byte shift register, registered serial line and last-byte copy

module txShifter import uartFramePkg::*; (
   input  logic    CLOCK_50,
   input  logic    reset,
   txLinkIf.shift  link,
   input  uartByte charByte,   // Byte from the character source
   output logic    uartTxd,    // Serial line, high at rest
   output uartByte lastByte    // Byte of the current or last frame
);

   uartByte shiftReg;      // Remaining data bits, LSB next
   logic    advanceSeen;   // Line has been driven since reset

   ////////////////////////////////////////////////////////////////////////////
   // Data path
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge CLOCK_50) begin
      if (link.load) begin
         shiftReg <= charByte;
      end else if (link.shiftEn) begin
         shiftReg <= shiftReg >> 1;   // Zero fill from the top
      end
   end

   // Line register, glitch free on the pin
   always_ff @(posedge CLOCK_50) begin
      if (reset) begin
         uartTxd     <= 1'b1;   // Mark
         lastByte    <= '0;
         advanceSeen <= 1'b0;
      end else begin
         if (link.advance) begin
            advanceSeen <= 1'b1;
            case (link.lineSel)
               lineStart: uartTxd <= 1'b0;
               lineData:  uartTxd <= shiftReg[0];   // Old LSB
               default:   uartTxd <= 1'b1;
            endcase
         end
         if (link.load) begin
            lastByte <= charByte;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Until the controller first drives the line it rests at mark
   idleUntilAdvance: assert property (
      @(posedge CLOCK_50) disable iff (reset)
      !advanceSeen |-> uartTxd
   );

endmodule

//--- src/serialBeacon.sv
// UART character beacon, top level
// Sends '0' to 'z' over and over as 8N1 frames on uartTxd

module serialBeacon import uartFramePkg::*; #(
   parameter int unsigned BAUD_DIVIDER = uartRatePkg::BAUD_DIVIDER,   // Cycles per bit
   parameter int unsigned CHAR_PERIOD  = uartRatePkg::CHAR_PERIOD     // Cycles per char
) (
   input  logic    CLOCK_50,
   input  logic    reset,
   output logic    uartTxd,     // Serial out
   output logic    txIdle,      // Transmitter between frames
   output logic    frameDone,   // End of frame pulse
   output uartByte lastByte     // Byte last loaded for sending
);

   logic    baudTick;
   logic    sendNew;
   uartByte charByte;

   txLinkIf link ();   // Controller to shifter

   baudTimer #(
      .BAUD_DIVIDER (BAUD_DIVIDER)
   ) baudTimerInst (
      .CLOCK_50 (CLOCK_50),
      .reset    (reset),
      .baudTick (baudTick)
   );

   charSource #(
      .CHAR_PERIOD (CHAR_PERIOD)
   ) charSourceInst (
      .CLOCK_50 (CLOCK_50),
      .reset    (reset),
      .sendNew  (sendNew),
      .charByte (charByte)
   );

   txControl txControlInst (
      .CLOCK_50  (CLOCK_50),
      .reset     (reset),
      .baudTick  (baudTick),
      .sendNew   (sendNew),
      .link      (link.ctrl),
      .txIdle    (txIdle),
      .frameDone (frameDone)
   );

   txShifter txShifterInst (
      .CLOCK_50 (CLOCK_50),
      .reset    (reset),
      .link     (link.shift),
      .charByte (charByte),
      .uartTxd  (uartTxd),
      .lastByte (lastByte)
   );

endmodule

//--- verif/serialBeaconTb.sv
// Testbench for the UART character beacon
// Decodes 8N1 frames off uartTxd, checks framing, code sequence,
// status outputs and recovery from a reset in the middle of a frame

module serialBeaconTb import uartFramePkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int BIT_CYCLES    = 8;                 // Shrunk baud divider
   localparam int CHAR_CYCLES   = 120;               // Shrunk character period
   localparam int FRAME_CYCLES  = 10 * BIT_CYCLES;   // Start, 8 data, stop
   localparam int RESET_CYCLES  = 8;
   localparam int START_TIMEOUT = 400;               // Cycles to wait for a start bit
   localparam int NUM_CODES     = int'(LAST_CHAR) - int'(FIRST_CHAR) + 1;
   localparam int NUM_ROWS      = 3;

   typedef struct {
      int   frames;       // Frames decoded in this row
      logic resetAfter;   // Reset inside the frame that follows
   } stimRow;

   // Every row starts right after a reset, so counting restarts at '0'
   stimRow stimTable [NUM_ROWS] = '{
      '{3,  1'b1},    // '0' to '2', then reset mid frame
      '{80, 1'b1},    // Wraps after 'z', ends on '4'
      '{4,  1'b0}     // '0' to '3'
   };

   logic        CLOCK_50;
   logic        reset;
   logic        uartTxd;
   logic        txIdle;
   logic        frameDone;
   uartByte     lastByte;
   int unsigned rngState;

   serialBeacon #(
      .BAUD_DIVIDER (BIT_CYCLES),
      .CHAR_PERIOD  (CHAR_CYCLES)
   ) UUT (
      .CLOCK_50  (CLOCK_50),
      .reset     (reset),
      .uartTxd   (uartTxd),
      .txIdle    (txIdle),
      .frameDone (frameDone),
      .lastByte  (lastByte)
   );

   initial begin
      CLOCK_50 = 1'b0;
      forever #5 CLOCK_50 = ~CLOCK_50;   // 100 MHz sim clock, 10 ns
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic failNow(input string msg);
      $display("%s", msg);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   function automatic int unsigned xorshift32(input int unsigned x);
      int unsigned v;
      v = x;
      v ^= v << 13;
      v ^= v >> 17;
      v ^= v << 5;
      return v;
   endfunction

   // n-th code after reset, '0' up to 'z' and round again
   function automatic uartByte expectedChar(input int index);
      return uartByte'(int'(FIRST_CHAR) + index % NUM_CODES);
   endfunction

   task automatic checkIdleLevels();
      assert (uartTxd === 1'b1 && txIdle === 1'b1 && frameDone === 1'b0) else
         failNow($sformatf("MISMATCH at %0d ns: idle expected, txd=%b idle=%b done=%b",
                           $time, uartTxd, txIdle, frameDone));
   endtask

   // Reset seen by the DUT from the second sample on
   task automatic applyReset();
      @(posedge CLOCK_50);
      reset <= 1'b1;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         @(negedge CLOCK_50);
         if (i > 0) begin
            checkIdleLevels();   // Line and status back at rest at once
         end
      end
      @(posedge CLOCK_50);
      reset <= 1'b0;
   endtask

   // Returns on the first falling-edge sample with the line low
   task automatic waitForStart();
      int waited;
      waited = 0;
      @(negedge CLOCK_50);
      while (uartTxd !== 1'b0) begin
         checkIdleLevels();
         waited++;
         if (waited > START_TIMEOUT) begin
            failNow("Timeout: no start bit appeared on uartTxd");
         end
         @(negedge CLOCK_50);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Line decoder, mid-bit sampling plus per-cycle status checks
   ////////////////////////////////////////////////////////////////////////////

   task automatic receiveFrame(output uartByte data, output logic startLevel,
                               output logic stopLevel);
      data       = '0;
      startLevel = 1'bx;
      stopLevel  = 1'bx;
      waitForStart();
      for (int i = 0; i < FRAME_CYCLES; i++) begin
         assert (txIdle === 1'b0 && frameDone === 1'b0) else
            failNow($sformatf("MISMATCH at %0d ns: busy frame, idle=%b done=%b",
                              $time, txIdle, frameDone));
         if (i == BIT_CYCLES / 2) begin
            startLevel = uartTxd;
         end else if (i == 9 * BIT_CYCLES + BIT_CYCLES / 2) begin
            stopLevel = uartTxd;
         end else if (i % BIT_CYCLES == BIT_CYCLES / 2) begin
            data = {uartTxd, data[7:1]};   // LSB arrives first
         end
         @(negedge CLOCK_50);
      end
      // End of frame, done pulse and idle together
      assert (frameDone === 1'b1 && txIdle === 1'b1 && lastByte === data) else
         failNow($sformatf("MISMATCH at %0d ns: frame end done=%b idle=%b last=%h rx=%h",
                           $time, frameDone, txIdle, lastByte, data));
      @(negedge CLOCK_50);
      assert (frameDone === 1'b0) else
         failNow($sformatf("MISMATCH at %0d ns: frameDone longer than one cycle", $time));
   endtask

   task automatic resetInsideFrame();
      int offset;
      rngState = xorshift32(rngState);
      offset   = 1 + int'(rngState % 70);   // Well inside the 80-cycle frame
      waitForStart();
      for (int i = 0; i < offset; i++) begin
         assert (txIdle === 1'b0) else
            failNow($sformatf("MISMATCH at %0d ns: txIdle high mid frame", $time));
         @(negedge CLOCK_50);
      end
      applyReset();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      uartByte rxByte;
      logic    startLevel;
      logic    stopLevel;
      reset    <= 1'b1;
      rngState = 64;
      applyReset();
      for (int row = 0; row < NUM_ROWS; row++) begin
         for (int n = 0; n < stimTable[row].frames; n++) begin
            receiveFrame(rxByte, startLevel, stopLevel);
            assert (startLevel === 1'b0 && stopLevel === 1'b1) else
               failNow($sformatf("MISMATCH at %0d ns: framing start=%b stop=%b",
                                 $time, startLevel, stopLevel));
            assert (rxByte === expectedChar(n)) else
               failNow($sformatf("MISMATCH at %0d ns: frame %0d got %h expected %h",
                                 $time, n, rxByte, expectedChar(n)));
         end
         if (stimTable[row].resetAfter) begin
            resetInsideFrame();
         end
      end
      $display("*** PASSED ***");
      $finish;
   end

endmodule

//--- serialBeacon.f
common/uartFramePkg.sv
common/uartRatePkg.sv
common/txLinkIf.sv
src/baudTimer.sv
src/charSource.sv
uartTx/txControl.sv
uartTx/txShifter.sv
src/serialBeacon.sv
verif/serialBeaconTb.sv

//--- runSim.sh
#!/usr/bin/env bash
# Build and run the serialBeacon testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module serialBeaconTb \
   -f serialBeacon.f \
   -o serialBeaconSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

simOutput=$(./obj_dir/serialBeaconSim)
simStatus=$?
echo "$simOutput"
if [ $simStatus -ne 0 ]; then
   echo "Simulation exited with status $simStatus"
   exit 1
fi

if echo "$simOutput" | grep -qF '*** PASSED ***'; then
   exit 0
else
   echo "Pass message not found in simulation output"
   exit 1
fi
